//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // one fixed 64-bit bus, fetch returns half a word
    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [7:0]  strb_t;

    // arbiter control FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_RAM_WAIT,
        ARB_CLINT_WAIT,
        ARB_RETURN
    } arb_state_e;

    // ram port FSM, merge states serve partial-strobe writes
    typedef enum logic [1:0] {
        RMW_IDLE,
        RMW_READ,
        RMW_MERGE_READ,
        RMW_MERGE_WRITE
    } rmw_state_e;

    // strobed bytes come from new_word, the rest keep old_word
    function automatic data_t merge_bytes(input data_t old_word,
                                          input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- hw/soc_map_pkg.sv
package soc_map_pkg;

    // core-local timer window, everything outside it is ram
    localparam soc_bus_pkg::addr_t CLINT_BASE    = 64'h0000_0000_0200_0000;
    localparam soc_bus_pkg::addr_t CLINT_SIZE    = 64'h0000_0000_0001_0000;

    // timer registers inside the window
    localparam soc_bus_pkg::addr_t MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam soc_bus_pkg::addr_t MTIME_ADDR    = 64'h0000_0000_0200_bff8;

    // every byte lane written
    localparam soc_bus_pkg::strb_t STRB_FULL     = 8'hff;

endpackage

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic               clk,
    input  logic               i_rst_n,

    input  logic               i_ifetch_req,
    input  soc_bus_pkg::addr_t i_ifetch_addr,
    output soc_bus_pkg::inst_t o_ifetch_data,
    output logic               o_ifetch_ok,

    input  logic               i_data_req,
    input  logic               i_data_we,
    input  soc_bus_pkg::addr_t i_data_addr,
    input  soc_bus_pkg::data_t i_data_wdata,
    input  soc_bus_pkg::strb_t i_data_strb,
    output soc_bus_pkg::data_t o_data_rdata,
    output logic               o_data_ok,

    input  logic               i_ram_done,
    input  soc_bus_pkg::data_t i_ram_rdata,
    input  logic               i_clint_done,
    input  soc_bus_pkg::data_t i_clint_rdata,

    output logic               o_ram_start,
    output logic               o_clint_start,
    output logic               o_acc_we,
    output soc_bus_pkg::addr_t o_acc_addr,
    output soc_bus_pkg::data_t o_acc_wdata,
    output soc_bus_pkg::strb_t o_acc_strb
);

    soc_bus_pkg::arb_state_e state_q;
    logic                    owner_data_q;
    logic                    ram_start_q;
    logic                    clint_start_q;
    logic                    ifetch_ok_q;
    logic                    data_ok_q;

    logic                    acc_we_q;
    soc_bus_pkg::addr_t      acc_addr_q;
    soc_bus_pkg::data_t      acc_wdata_q;
    soc_bus_pkg::strb_t      acc_strb_q;
    soc_bus_pkg::data_t      rdata_q;

    logic                    grant;
    soc_bus_pkg::addr_t      sel_addr;
    logic                    sel_clint;

    // data port wins a tie
    assign grant    = i_data_req | i_ifetch_req;
    assign sel_addr = i_data_req ? i_data_addr : i_ifetch_addr;

    // timer window decode, only done here
    assign sel_clint = (sel_addr >= soc_map_pkg::CLINT_BASE) &&
                       (sel_addr <  soc_map_pkg::CLINT_BASE + soc_map_pkg::CLINT_SIZE);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= soc_bus_pkg::ARB_IDLE;
            owner_data_q  <= 1'b0;
            ram_start_q   <= 1'b0;
            clint_start_q <= 1'b0;
            ifetch_ok_q   <= 1'b0;
            data_ok_q     <= 1'b0;
        end else begin
            // starts and oks are single-cycle pulses
            ram_start_q   <= 1'b0;
            clint_start_q <= 1'b0;
            ifetch_ok_q   <= 1'b0;
            data_ok_q     <= 1'b0;
            case (state_q)
                soc_bus_pkg::ARB_IDLE: begin
                    if (grant) begin
                        owner_data_q <= i_data_req;
                        if (sel_clint) begin
                            clint_start_q <= 1'b1;
                            state_q       <= soc_bus_pkg::ARB_CLINT_WAIT;
                        end else begin
                            ram_start_q <= 1'b1;
                            state_q     <= soc_bus_pkg::ARB_RAM_WAIT;
                        end
                    end
                end
                soc_bus_pkg::ARB_RAM_WAIT: begin
                    if (i_ram_done) begin
                        data_ok_q   <= owner_data_q;
                        ifetch_ok_q <= !owner_data_q;
                        state_q     <= soc_bus_pkg::ARB_RETURN;
                    end
                end
                soc_bus_pkg::ARB_CLINT_WAIT: begin
                    if (i_clint_done) begin
                        data_ok_q   <= owner_data_q;
                        ifetch_ok_q <= !owner_data_q;
                        state_q     <= soc_bus_pkg::ARB_RETURN;
                    end
                end
                // ok is high here, requests are not sampled
                soc_bus_pkg::ARB_RETURN: begin
                    state_q <= soc_bus_pkg::ARB_IDLE;
                end
                default: begin
                    state_q <= soc_bus_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // latched access and returned word
    always_ff @(posedge clk) begin
        if (state_q == soc_bus_pkg::ARB_IDLE && grant) begin
            if (i_data_req) begin
                acc_we_q    <= i_data_we;
                acc_addr_q  <= i_data_addr;
                acc_wdata_q <= i_data_wdata;
                acc_strb_q  <= i_data_strb;
            end else begin
                // a fetch is always a full-word read
                acc_we_q    <= 1'b0;
                acc_addr_q  <= i_ifetch_addr;
                acc_wdata_q <= '0;
                acc_strb_q  <= soc_map_pkg::STRB_FULL;
            end
        end
        if (state_q == soc_bus_pkg::ARB_RAM_WAIT && i_ram_done) begin
            rdata_q <= i_ram_rdata;
        end
        if (state_q == soc_bus_pkg::ARB_CLINT_WAIT && i_clint_done) begin
            rdata_q <= i_clint_rdata;
        end
    end

    assign o_ram_start   = ram_start_q;
    assign o_clint_start = clint_start_q;
    assign o_acc_we      = acc_we_q;
    assign o_acc_addr    = acc_addr_q;
    assign o_acc_wdata   = acc_wdata_q;
    assign o_acc_strb    = acc_strb_q;

    assign o_data_ok     = data_ok_q;
    assign o_data_rdata  = rdata_q;
    assign o_ifetch_ok   = ifetch_ok_q;
    // address bit 2 picks the instruction half
    assign o_ifetch_data = acc_addr_q[2] ? rdata_q[63:32] : rdata_q[31:0];

endmodule

//--- hw/ram_port.sv
`timescale 1ns/1ps

module ram_port (
    input  logic               clk,
    input  logic               i_rst_n,

    input  logic               i_start,
    input  logic               i_we,
    input  soc_bus_pkg::addr_t i_addr,
    input  soc_bus_pkg::data_t i_wdata,
    input  soc_bus_pkg::strb_t i_strb,
    output logic               o_done,
    output soc_bus_pkg::data_t o_rdata,

    output logic               o_ram_read_ena,
    output soc_bus_pkg::addr_t o_ram_addr,
    input  soc_bus_pkg::data_t i_ram_rdata,
    output logic               o_ram_write_ena,
    output soc_bus_pkg::addr_t o_ram_write_addr,
    output soc_bus_pkg::data_t o_ram_write_data
);

    soc_bus_pkg::rmw_state_e state_q;
    logic                    done_q;
    // read result, or merged word on a partial write
    soc_bus_pkg::data_t      word_q;

    logic                    full_strb;
    logic                    start_read;
    logic                    start_write;

    assign full_strb   = (i_strb == soc_map_pkg::STRB_FULL);
    // partial writes read the old word first
    assign start_read  = (state_q == soc_bus_pkg::RMW_IDLE) && i_start &&
                         !(i_we && full_strb);
    assign start_write = (state_q == soc_bus_pkg::RMW_IDLE) && i_start &&
                         i_we && full_strb;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= soc_bus_pkg::RMW_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                soc_bus_pkg::RMW_IDLE: begin
                    if (start_write) begin
                        done_q <= 1'b1;
                    end else if (start_read) begin
                        state_q <= i_we ? soc_bus_pkg::RMW_MERGE_READ
                                        : soc_bus_pkg::RMW_READ;
                    end
                end
                soc_bus_pkg::RMW_READ: begin
                    done_q  <= 1'b1;
                    state_q <= soc_bus_pkg::RMW_IDLE;
                end
                soc_bus_pkg::RMW_MERGE_READ: begin
                    state_q <= soc_bus_pkg::RMW_MERGE_WRITE;
                end
                soc_bus_pkg::RMW_MERGE_WRITE: begin
                    done_q  <= 1'b1;
                    state_q <= soc_bus_pkg::RMW_IDLE;
                end
                default: begin
                    state_q <= soc_bus_pkg::RMW_IDLE;
                end
            endcase
        end
    end

    // ram data is valid the cycle after read_ena
    always_ff @(posedge clk) begin
        if (state_q == soc_bus_pkg::RMW_READ) begin
            word_q <= i_ram_rdata;
        end else if (state_q == soc_bus_pkg::RMW_MERGE_READ) begin
            word_q <= soc_bus_pkg::merge_bytes(i_ram_rdata, i_wdata, i_strb);
        end
    end

    assign o_ram_read_ena   = start_read;
    assign o_ram_addr       = i_addr;
    assign o_ram_write_ena  = start_write || (state_q == soc_bus_pkg::RMW_MERGE_WRITE);
    assign o_ram_write_addr = i_addr;
    assign o_ram_write_data = (state_q == soc_bus_pkg::RMW_MERGE_WRITE) ? word_q : i_wdata;

    assign o_done  = done_q;
    assign o_rdata = word_q;

endmodule

//--- hw/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
    input  logic               clk,
    input  logic               i_rst_n,

    input  logic               i_start,
    input  logic               i_we,
    input  soc_bus_pkg::addr_t i_addr,
    input  soc_bus_pkg::data_t i_wdata,
    input  soc_bus_pkg::strb_t i_strb,
    output logic               o_done,
    output soc_bus_pkg::data_t o_rdata,

    output logic               o_timer_irq
);

    soc_bus_pkg::data_t mtime_q;
    soc_bus_pkg::data_t mtimecmp_q;
    soc_bus_pkg::data_t rdata_q;
    logic               done_q;
    logic               irq_q;

    logic               sel_mtime;
    logic               sel_mtimecmp;
    logic               wr_mtime;
    logic               wr_mtimecmp;

    // register select, other window addresses read zero
    assign sel_mtime    = (i_addr == soc_map_pkg::MTIME_ADDR);
    assign sel_mtimecmp = (i_addr == soc_map_pkg::MTIMECMP_ADDR);
    assign wr_mtime     = i_start && i_we && sel_mtime;
    assign wr_mtimecmp  = i_start && i_we && sel_mtimecmp;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mtime_q    <= '0;
            // all ones keeps the interrupt low out of reset
            mtimecmp_q <= '1;
            done_q     <= 1'b0;
            irq_q      <= 1'b0;
        end else begin
            done_q <= i_start;
            // a software write wins over the tick
            if (wr_mtime) begin
                mtime_q <= soc_bus_pkg::merge_bytes(mtime_q, i_wdata, i_strb);
            end else begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_mtimecmp) begin
                mtimecmp_q <= soc_bus_pkg::merge_bytes(mtimecmp_q, i_wdata, i_strb);
            end
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge clk) begin
        if (i_start && !i_we) begin
            if (sel_mtime) begin
                rdata_q <= mtime_q;
            end else if (sel_mtimecmp) begin
                rdata_q <= mtimecmp_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign o_done      = done_q;
    assign o_rdata     = rdata_q;
    assign o_timer_irq = irq_q;

endmodule

//--- hw/soc_top.sv
`timescale 1ns/1ps

module soc_top (
    input  logic               clk,
    input  logic               i_rst_n,

    // instruction fetch port
    input  logic               i_ifetch_req,
    input  soc_bus_pkg::addr_t i_ifetch_addr,
    output soc_bus_pkg::inst_t o_ifetch_data,
    output logic               o_ifetch_ok,

    // load/store port
    input  logic               i_data_req,
    input  logic               i_data_we,
    input  soc_bus_pkg::addr_t i_data_addr,
    input  soc_bus_pkg::data_t i_data_wdata,
    input  soc_bus_pkg::strb_t i_data_strb,
    output soc_bus_pkg::data_t o_data_rdata,
    output logic               o_data_ok,

    // external synchronous ram
    output logic               o_ram_read_ena,
    output soc_bus_pkg::addr_t o_ram_addr,
    input  soc_bus_pkg::data_t i_ram_rdata,
    output logic               o_ram_write_ena,
    output soc_bus_pkg::addr_t o_ram_write_addr,
    output soc_bus_pkg::data_t o_ram_write_data,

    output logic               o_timer_irq
);

    // shared access from the arbiter
    logic               acc_we;
    soc_bus_pkg::addr_t acc_addr;
    soc_bus_pkg::data_t acc_wdata;
    soc_bus_pkg::strb_t acc_strb;

    logic               ram_start;
    logic               ram_done;
    soc_bus_pkg::data_t ram_rdata;

    logic               clint_start;
    logic               clint_done;
    soc_bus_pkg::data_t clint_rdata;

    bus_arbiter u_bus_arbiter (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_ifetch_req  (i_ifetch_req),
        .i_ifetch_addr (i_ifetch_addr),
        .o_ifetch_data (o_ifetch_data),
        .o_ifetch_ok   (o_ifetch_ok),
        .i_data_req    (i_data_req),
        .i_data_we     (i_data_we),
        .i_data_addr   (i_data_addr),
        .i_data_wdata  (i_data_wdata),
        .i_data_strb   (i_data_strb),
        .o_data_rdata  (o_data_rdata),
        .o_data_ok     (o_data_ok),
        .i_ram_done    (ram_done),
        .i_ram_rdata   (ram_rdata),
        .i_clint_done  (clint_done),
        .i_clint_rdata (clint_rdata),
        .o_ram_start   (ram_start),
        .o_clint_start (clint_start),
        .o_acc_we      (acc_we),
        .o_acc_addr    (acc_addr),
        .o_acc_wdata   (acc_wdata),
        .o_acc_strb    (acc_strb)
    );

    ram_port u_ram_port (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_start          (ram_start),
        .i_we             (acc_we),
        .i_addr           (acc_addr),
        .i_wdata          (acc_wdata),
        .i_strb           (acc_strb),
        .i_ram_rdata      (i_ram_rdata),
        .o_done           (ram_done),
        .o_rdata          (ram_rdata),
        .o_ram_read_ena   (o_ram_read_ena),
        .o_ram_addr       (o_ram_addr),
        .o_ram_write_ena  (o_ram_write_ena),
        .o_ram_write_addr (o_ram_write_addr),
        .o_ram_write_data (o_ram_write_data)
    );

    clint_timer u_clint_timer (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (clint_start),
        .i_we        (acc_we),
        .i_addr      (acc_addr),
        .i_wdata     (acc_wdata),
        .i_strb      (acc_strb),
        .o_done      (clint_done),
        .o_rdata     (clint_rdata),
        .o_timer_irq (o_timer_irq)
    );

endmodule

//--- verification/ram_model.sv
`timescale 1ns/1ps

module ram_model (
    input  logic               clk,
    input  logic               i_read_ena,
    input  soc_bus_pkg::addr_t i_addr,
    output soc_bus_pkg::data_t o_rdata,
    input  logic               i_write_ena,
    input  soc_bus_pkg::addr_t i_write_addr,
    input  soc_bus_pkg::data_t i_write_data
);

    localparam int DEPTH = 1024;

    // 8-byte words, upper address bits alias
    soc_bus_pkg::data_t mem [DEPTH];

    initial begin
        o_rdata = '0;
        // fill depends on every index bit
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {32'(i) ^ 32'h5eed_0000, ~32'(i)};
        end
    end

    // read data shows up the cycle after read_ena
    always @(posedge clk) begin
        if (i_write_ena) begin
            mem[i_write_addr[12:3]] <= i_write_data;
        end
        if (i_read_ena) begin
            o_rdata <= mem[i_addr[12:3]];
        end
    end

endmodule

//--- verification/soc_top_tb.sv
`timescale 1ns/1ps

module soc_top_tb;

    localparam int ROUNDS = 8;
    // six per round, four at the window edges, four in races, seven on the timer
    localparam int NUM_ACCESSES = ROUNDS * 6 + 15;
    localparam int CYCLE_LIMIT  = 60 * NUM_ACCESSES + 200;
    localparam int IRQ_DIST     = 40;
    localparam soc_bus_pkg::addr_t RAM_BASE = 64'h0000_0000_8000_0000;

    logic               clk;
    logic               i_rst_n;
    logic               i_ifetch_req;
    soc_bus_pkg::addr_t i_ifetch_addr;
    soc_bus_pkg::inst_t o_ifetch_data;
    logic               o_ifetch_ok;
    logic               i_data_req;
    logic               i_data_we;
    soc_bus_pkg::addr_t i_data_addr;
    soc_bus_pkg::data_t i_data_wdata;
    soc_bus_pkg::strb_t i_data_strb;
    soc_bus_pkg::data_t o_data_rdata;
    logic               o_data_ok;
    logic               o_ram_read_ena;
    soc_bus_pkg::addr_t o_ram_addr;
    soc_bus_pkg::data_t i_ram_rdata;
    logic               o_ram_write_ena;
    soc_bus_pkg::addr_t o_ram_write_addr;
    soc_bus_pkg::data_t o_ram_write_data;
    logic               o_timer_irq;

    // predicted ram contents
    soc_bus_pkg::data_t ref_mem [1024];

    // expectations set before each access
    soc_bus_pkg::data_t exp_rdata;
    soc_bus_pkg::data_t lower_bound;
    soc_bus_pkg::inst_t exp_inst;
    soc_bus_pkg::addr_t exp_rd_addr;
    soc_bus_pkg::addr_t exp_wr_addr;
    soc_bus_pkg::data_t exp_wr_data;
    logic rd_chk = 1'b0;
    logic gt_chk = 1'b0;
    logic inst_chk = 1'b0;
    logic addr_chk = 1'b0;
    logic wr_chk = 1'b0;
    logic cnt_chk = 1'b0;
    logic timer_busy = 1'b0;
    logic irq_low_chk = 1'b0;
    logic irq_due = 1'b0;
    logic race_active = 1'b0;
    logic data_seen = 1'b0;

    int cycles = 0;
    int mismatches = 0;
    int faults = 0;
    int rd_pulses = 0;
    int wr_pulses = 0;
    int rd_base = 0;
    int wr_base = 0;
    int exp_rd_cnt = 0;
    int exp_wr_cnt = 0;

    soc_top uut (.*);

    ram_model u_ram (
        .clk          (clk),
        .i_read_ena   (o_ram_read_ena),
        .i_addr       (o_ram_addr),
        .o_rdata      (i_ram_rdata),
        .i_write_ena  (o_ram_write_ena),
        .i_write_addr (o_ram_write_addr),
        .i_write_data (o_ram_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // strobe counts and run limit
    always @(posedge clk) begin
        cycles    <= cycles + 1;
        rd_pulses <= rd_pulses + int'(o_ram_read_ena);
        wr_pulses <= wr_pulses + int'(o_ram_write_ena);
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles: %0d mismatches, %0d protocol faults",
                     cycles, mismatches, faults);
            $display("tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input soc_bus_pkg::data_t got,
                                   input soc_bus_pkg::data_t exp);
        mismatches++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic report_fault(input string what);
        faults++;
        $display("%s at cycle %0d", what, cycles);
    endtask

    a_data_rdata: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_data_ok && rd_chk |-> o_data_rdata == exp_rdata)
        else report_mismatch("o_data_rdata", $sampled(o_data_rdata), exp_rdata);
    a_mtime_grows: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_data_ok && gt_chk |-> o_data_rdata > lower_bound)
        else report_mismatch("o_data_rdata (mtime)", $sampled(o_data_rdata), lower_bound + 1);
    a_ifetch_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ifetch_ok && inst_chk |-> o_ifetch_data == exp_inst)
        else report_mismatch("o_ifetch_data", 64'($sampled(o_ifetch_data)), 64'(exp_inst));
    a_read_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ram_read_ena && addr_chk |-> o_ram_addr == exp_rd_addr)
        else report_mismatch("o_ram_addr", $sampled(o_ram_addr), exp_rd_addr);
    a_write_addr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ram_write_ena && wr_chk |-> o_ram_write_addr == exp_wr_addr)
        else report_mismatch("o_ram_write_addr", $sampled(o_ram_write_addr), exp_wr_addr);
    a_write_data: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ram_write_ena && wr_chk |-> o_ram_write_data == exp_wr_data)
        else report_mismatch("o_ram_write_data", $sampled(o_ram_write_data), exp_wr_data);
    a_strobe_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_data_ok || o_ifetch_ok) && cnt_chk |->
            (rd_pulses - rd_base == exp_rd_cnt) && (wr_pulses - wr_base == exp_wr_cnt))
        else report_fault("wrong number of RAM read or write strobes for one access");
    a_timer_no_ram: assert property (@(posedge clk) disable iff (!i_rst_n)
        timer_busy |-> !o_ram_read_ena && !o_ram_write_ena)
        else report_fault("RAM strobe raised during a timer access");
    a_irq_low: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_data_ok && irq_low_chk |-> !o_timer_irq)
        else report_mismatch("o_timer_irq", 64'($sampled(o_timer_irq)), 64'h0);
    a_irq_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
        irq_due |-> o_timer_irq)
        else report_fault("timer interrupt did not rise after the compare write");
    a_ok_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        !((o_data_ok && !i_data_req) || (o_ifetch_ok && !i_ifetch_req)))
        else report_fault("ok pulse without a held request");
    a_data_first: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ifetch_ok && race_active |-> data_seen)
        else report_fault("fetch served before the data port in a tie");
    a_reset_low: assert property (@(posedge clk)
        !i_rst_n && cycles >= 2 |->
            !(o_ifetch_ok || o_data_ok || o_ram_read_ena || o_ram_write_ena || o_timer_irq))
        else report_fault("output not low during reset");

    // new bytes under the strobe, old bytes elsewhere
    function automatic soc_bus_pkg::data_t apply_write(input soc_bus_pkg::data_t old_word,
                                                       input soc_bus_pkg::data_t new_word,
                                                       input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::data_t mask;
        for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic soc_bus_pkg::inst_t fetch_half(input soc_bus_pkg::addr_t addr);
        return addr[2] ? ref_mem[addr[12:3]][63:32] : ref_mem[addr[12:3]][31:0];
    endfunction

    // holds the request through the ok cycle and drops it one cycle later
    task automatic run_access(input logic fetch, input logic we,
                              input soc_bus_pkg::addr_t addr,
                              input soc_bus_pkg::data_t wdata,
                              input soc_bus_pkg::strb_t strb,
                              output soc_bus_pkg::data_t rdata);
        @(negedge clk);
        rd_base     = rd_pulses;
        wr_base     = wr_pulses;
        exp_rd_addr = addr;
        addr_chk    = 1'b1;
        if (fetch) begin
            i_ifetch_req  = 1'b1;
            i_ifetch_addr = addr;
        end else begin
            i_data_req   = 1'b1;
            i_data_we    = we;
            i_data_addr  = addr;
            i_data_wdata = wdata;
            i_data_strb  = strb;
        end
        do @(negedge clk); while (!(o_data_ok || o_ifetch_ok));
        rdata = o_data_rdata;
        @(negedge clk);
        i_data_req   = 1'b0;
        i_ifetch_req = 1'b0;
        addr_chk     = 1'b0;
    endtask

    task automatic ram_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
                             input soc_bus_pkg::strb_t strb);
        soc_bus_pkg::data_t unused;
        exp_wr_addr = addr;
        exp_wr_data = apply_write(ref_mem[addr[12:3]], wdata, strb);
        exp_rd_cnt  = (strb == soc_map_pkg::STRB_FULL) ? 0 : 1;
        exp_wr_cnt  = 1;
        wr_chk      = 1'b1;
        cnt_chk     = 1'b1;
        run_access(1'b0, 1'b1, addr, wdata, strb, unused);
        ref_mem[addr[12:3]] = exp_wr_data;
        wr_chk  = 1'b0;
        cnt_chk = 1'b0;
    endtask

    task automatic ram_read(input soc_bus_pkg::addr_t addr, input logic fetch);
        soc_bus_pkg::data_t unused;
        exp_rdata  = ref_mem[addr[12:3]];
        exp_inst   = fetch_half(addr);
        exp_rd_cnt = 1;
        exp_wr_cnt = 0;
        rd_chk     = !fetch;
        inst_chk   = fetch;
        cnt_chk    = 1'b1;
        run_access(fetch, 1'b0, addr, '0, soc_map_pkg::STRB_FULL, unused);
        rd_chk   = 1'b0;
        inst_chk = 1'b0;
        cnt_chk  = 1'b0;
    endtask

    task automatic timer_access(input logic we, input soc_bus_pkg::addr_t addr,
                                input soc_bus_pkg::data_t wdata,
                                output soc_bus_pkg::data_t rdata);
        exp_rd_cnt = 0;
        exp_wr_cnt = 0;
        timer_busy = 1'b1;
        cnt_chk    = 1'b1;
        run_access(1'b0, we, addr, wdata, soc_map_pkg::STRB_FULL, rdata);
        timer_busy = 1'b0;
        cnt_chk    = 1'b0;
    endtask

    // data read and fetch raised on the same edge
    task automatic race(input soc_bus_pkg::addr_t daddr, input soc_bus_pkg::addr_t faddr);
        @(negedge clk);
        exp_rdata     = ref_mem[daddr[12:3]];
        exp_inst      = fetch_half(faddr);
        rd_chk        = 1'b1;
        inst_chk      = 1'b1;
        data_seen     = 1'b0;
        race_active   = 1'b1;
        i_data_req    = 1'b1;
        i_data_we     = 1'b0;
        i_data_addr   = daddr;
        i_data_strb   = soc_map_pkg::STRB_FULL;
        i_ifetch_req  = 1'b1;
        i_ifetch_addr = faddr;
        do @(negedge clk); while (!o_data_ok);
        data_seen = 1'b1;
        @(negedge clk);
        i_data_req = 1'b0;
        do @(negedge clk); while (!o_ifetch_ok);
        @(negedge clk);
        i_ifetch_req = 1'b0;
        race_active  = 1'b0;
        rd_chk       = 1'b0;
        inst_chk     = 1'b0;
    endtask

    initial begin
        soc_bus_pkg::addr_t addr;
        soc_bus_pkg::addr_t low_edge;
        soc_bus_pkg::addr_t high_edge;
        soc_bus_pkg::data_t mtime_val;
        soc_bus_pkg::data_t unused;
        void'($urandom(32'h38c3));
        i_rst_n       = 1'b0;
        i_ifetch_req  = 1'b0;
        i_ifetch_addr = '0;
        i_data_req    = 1'b0;
        i_data_we     = 1'b0;
        i_data_addr   = '0;
        i_data_wdata  = '0;
        i_data_strb   = '0;
        low_edge      = soc_map_pkg::CLINT_BASE - 64'd8;
        high_edge     = soc_map_pkg::CLINT_BASE + soc_map_pkg::CLINT_SIZE;
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        for (int r = 0; r < ROUNDS; r++) begin
            addr = RAM_BASE + 64'(($urandom % 1024) * 8);
            ram_write(addr, {$urandom, $urandom}, soc_map_pkg::STRB_FULL);
            ram_read(addr, 1'b0);
            ram_write(addr, {$urandom, $urandom}, 8'($urandom % 254 + 1));
            ram_read(addr, 1'b0);
            ram_read(addr, 1'b1);
            ram_read(addr | 64'h4, 1'b1);
        end

        // just outside the timer window is still ram
        ram_write(low_edge, {$urandom, $urandom}, soc_map_pkg::STRB_FULL);
        ram_read(low_edge, 1'b0);
        ram_write(high_edge, {$urandom, $urandom}, soc_map_pkg::STRB_FULL);
        ram_read(high_edge, 1'b0);

        race(addr, addr | 64'h4);
        race(low_edge, addr);

        timer_access(1'b0, soc_map_pkg::MTIME_ADDR, '0, mtime_val);
        lower_bound = mtime_val;
        gt_chk      = 1'b1;
        timer_access(1'b0, soc_map_pkg::MTIME_ADDR, '0, unused);
        gt_chk = 1'b0;

        // compare just ahead of mtime, then wait for the interrupt
        timer_access(1'b0, soc_map_pkg::MTIME_ADDR, '0, mtime_val);
        irq_low_chk = 1'b1;
        timer_access(1'b1, soc_map_pkg::MTIMECMP_ADDR, mtime_val + 64'(IRQ_DIST), unused);
        irq_low_chk = 1'b0;
        for (int i = 0; i < IRQ_DIST + 10 && !o_timer_irq; i++) begin
            @(negedge clk);
        end
        irq_due = 1'b1;
        @(negedge clk);
        irq_due     = 1'b0;
        irq_low_chk = 1'b1;
        timer_access(1'b1, soc_map_pkg::MTIMECMP_ADDR, '1, unused);
        irq_low_chk = 1'b0;

        // unmapped timer address ignores the write and reads zero
        timer_access(1'b1, soc_map_pkg::CLINT_BASE + 64'h100, {$urandom, $urandom}, unused);
        exp_rdata = '0;
        rd_chk    = 1'b1;
        timer_access(1'b0, soc_map_pkg::CLINT_BASE + 64'h100, '0, unused);
        rd_chk = 1'b0;

        repeat (5) @(negedge clk);
        $display("run summary: %0d mismatches, %0d protocol faults", mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- soc_mem.f
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/bus_arbiter.sv
hw/ram_port.sv
hw/clint_timer.sv
hw/soc_top.sv
verification/ram_model.sv
verification/soc_top_tb.sv

//--- Bender.yml
package:
  name: soc_mem

sources:
  # packages first, then the design
  - files:
      - hw/soc_bus_pkg.sv
      - hw/soc_map_pkg.sv
      - hw/bus_arbiter.sv
      - hw/ram_port.sv
      - hw/clint_timer.sv
      - hw/soc_top.sv

  # simulation only
  - target: test
    files:
      - verification/ram_model.sv
      - verification/soc_top_tb.sv
